// File: tx_sched_consts.svh
// Fixed sizes, register offsets and identity values of the transmit scheduler, included by RTL and testbench
`ifndef TX_SCHED_CONSTS_SVH
`define TX_SCHED_CONSTS_SVH

// Queue and timeslot sizing
`define TX_QUEUE_COUNT        8
`define TX_QUEUE_W            3
`define TDMA_SLOT_COUNT       4
`define TDMA_SLOT_W           2

// Request fields
`define TX_TAG_W              8
`define TX_DEST_W             8

// Register port
`define REG_ADDR_W            16
`define REG_DATA_W            32

// Register map in byte offsets of 32-bit words
`define REG_BLOCK_TYPE        16'h0000
`define REG_BLOCK_VER         16'h0004
`define REG_SCHED_CTRL        16'h0010  // Bit 0 enable
`define REG_SCHED_DEST        16'h0014
`define REG_TDMA_CTRL         16'h0020  // Bit 0 enable
`define REG_TDMA_STATUS       16'h0024  // Bit 0 running, bits 9:8 current slot
`define REG_TDMA_SLOT_PERIOD  16'h0028  // Slot length in cycles
`define REG_TDMA_MASK_BASE    16'h0040  // Mask i at base + 4*i

// Identity words
`define BLOCK_TYPE_ID         32'h0000C004
`define BLOCK_VER_ID          32'h00000300

`define DEST_RESET            8'h00

`endif

// File: tx_sched_pkg.sv
// Vector types shared by the transmit scheduler modules, referenced as tx_sched_pkg::name
`include "tx_sched_consts.svh"

package tx_sched_pkg;

    // Queue side
    typedef logic [`TX_QUEUE_W-1:0]     queue_idx_t;
    typedef logic [`TX_QUEUE_COUNT-1:0] queue_mask_t;  // One bit per queue

    // TDMA side
    typedef logic [`TDMA_SLOT_W-1:0]    slot_idx_t;
    typedef logic [15:0]                slot_period_t; // Slot length in clock cycles

    // Transmit request fields
    typedef logic [`TX_TAG_W-1:0]       tx_tag_t;
    typedef logic [`TX_DEST_W-1:0]      tx_dest_t;

    // Host register port
    typedef logic [`REG_ADDR_W-1:0]     reg_addr_t;
    typedef logic [`REG_DATA_W-1:0]     reg_data_t;

endpackage

// File: tx_sched_ifs.sv
// TDMA configuration and timeslot interfaces, instantiated once each inside the scheduler top level
`timescale 1ns/1ps

// Register file to timeslot generator and slot mask table
interface tdma_cfg_if;
    logic                        tdma_enable;
    tx_sched_pkg::slot_period_t  slot_period;
    logic                        mask_wr;       // Single-cycle write strobe
    tx_sched_pkg::slot_idx_t     mask_wr_slot;
    tx_sched_pkg::queue_mask_t   mask_wr_data;
    tx_sched_pkg::slot_idx_t     mask_rd_slot;
    tx_sched_pkg::queue_mask_t   mask_rd_data;  // Combinational from the table
    logic                        running;
    tx_sched_pkg::slot_idx_t     cur_slot;

    modport regs (
        output tdma_enable, slot_period,
        output mask_wr, mask_wr_slot, mask_wr_data, mask_rd_slot,
        input  mask_rd_data, running, cur_slot
    );

    modport gen (
        input  tdma_enable, slot_period,
        output running, cur_slot
    );

    modport ctrl (
        input  mask_wr, mask_wr_slot, mask_wr_data, mask_rd_slot,
        output mask_rd_data
    );
endinterface

// Timeslot generator to queue gating with levels plus two strobes
interface timeslot_if;
    tx_sched_pkg::slot_idx_t  slot_index;
    logic                     slot_start;      // First cycle of every slot
    logic                     schedule_start;  // First cycle after TDMA enable
    logic                     running;

    modport src (
        output slot_index, slot_start, schedule_start, running
    );

    modport dst (
        input  slot_index, slot_start, schedule_start, running
    );
endinterface

// File: tx_sched_regs.sv
// Control register file of the transmit scheduler, decodes host reads and writes and drives the config
`timescale 1ns/1ps
`include "tx_sched_consts.svh"

module tx_sched_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  tx_sched_pkg::reg_addr_t wr_addr,
    input  tx_sched_pkg::reg_data_t wr_data,
    input  logic                    wr_en,
    output logic                    wr_ack,
    input  tx_sched_pkg::reg_addr_t rd_addr,
    input  logic                    rd_en,
    output tx_sched_pkg::reg_data_t rd_data,
    output logic                    rd_ack,
    tdma_cfg_if.regs                cfg,
    output logic                    sched_enable,
    output tx_sched_pkg::tx_dest_t  dest
);
    tx_sched_pkg::reg_addr_t    wr_word;
    tx_sched_pkg::reg_addr_t    rd_word;
    logic                       wr_mask_hit;
    logic                       rd_mask_hit;
    logic                       wr_hit;
    logic                       rd_hit;
    tx_sched_pkg::reg_data_t    rd_mux;
    logic                       tdma_enable_q;
    tx_sched_pkg::slot_period_t slot_period_q;

    // Word aligned addresses
    assign wr_word = {wr_addr[`REG_ADDR_W-1:2], 2'b00};
    assign rd_word = {rd_addr[`REG_ADDR_W-1:2], 2'b00};

    assign wr_mask_hit = (wr_word >= `REG_TDMA_MASK_BASE) &&
                         (wr_word < `REG_TDMA_MASK_BASE + 4 * `TDMA_SLOT_COUNT);
    assign rd_mask_hit = (rd_word >= `REG_TDMA_MASK_BASE) &&
                         (rd_word < `REG_TDMA_MASK_BASE + 4 * `TDMA_SLOT_COUNT);

    // Mask writes go straight to the table so they land on the acking edge
    assign cfg.mask_wr      = wr_en && !wr_ack && wr_mask_hit;
    assign cfg.mask_wr_slot = wr_addr[`TDMA_SLOT_W+1:2];
    assign cfg.mask_wr_data = tx_sched_pkg::queue_mask_t'(wr_data);
    assign cfg.mask_rd_slot = rd_addr[`TDMA_SLOT_W+1:2];

    assign cfg.tdma_enable = tdma_enable_q;
    assign cfg.slot_period = slot_period_q;

    // Only writable registers are decoded for writes
    always_comb begin
        case (wr_word)
            `REG_SCHED_CTRL,
            `REG_SCHED_DEST,
            `REG_TDMA_CTRL,
            `REG_TDMA_SLOT_PERIOD: wr_hit = 1'b1;
            default:               wr_hit = wr_mask_hit;
        endcase
    end

    always_comb begin
        rd_hit = 1'b1;
        rd_mux = '0;
        case (rd_word)
            `REG_BLOCK_TYPE:       rd_mux = `BLOCK_TYPE_ID;
            `REG_BLOCK_VER:        rd_mux = `BLOCK_VER_ID;
            `REG_SCHED_CTRL:       rd_mux = tx_sched_pkg::reg_data_t'(sched_enable);
            `REG_SCHED_DEST:       rd_mux = tx_sched_pkg::reg_data_t'(dest);
            `REG_TDMA_CTRL:        rd_mux = tx_sched_pkg::reg_data_t'(tdma_enable_q);
            `REG_TDMA_STATUS: begin
                rd_mux[0]                = cfg.running;
                rd_mux[8 +: `TDMA_SLOT_W] = cfg.cur_slot;
            end
            `REG_TDMA_SLOT_PERIOD: rd_mux = tx_sched_pkg::reg_data_t'(slot_period_q);
            default: begin
                rd_hit = rd_mask_hit;
                rd_mux = tx_sched_pkg::reg_data_t'(cfg.mask_rd_data);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ack        <= 1'b0;
            rd_ack        <= 1'b0;
            sched_enable  <= 1'b0;
            dest          <= `DEST_RESET;
            tdma_enable_q <= 1'b0;
            slot_period_q <= '0;
        end else begin
            wr_ack <= wr_en && !wr_ack && wr_hit;  // Undecoded address never acks
            rd_ack <= rd_en && !rd_ack && rd_hit;
            if (wr_en && !wr_ack) begin
                case (wr_word)
                    `REG_SCHED_CTRL:       sched_enable  <= wr_data[0];
                    `REG_SCHED_DEST:       dest          <= tx_sched_pkg::tx_dest_t'(wr_data);
                    `REG_TDMA_CTRL:        tdma_enable_q <= wr_data[0];
                    `REG_TDMA_SLOT_PERIOD: slot_period_q <= tx_sched_pkg::slot_period_t'(wr_data);
                    default: ;
                endcase
            end
        end
    end

    // Read data captured on the sampling edge
    always_ff @(posedge clk) begin
        if (rd_en && !rd_ack) begin
            rd_data <= rd_mux;
        end
    end

    // A held enable must not produce a second ack
    a_wr_ack_pulse: assert property (@(posedge clk) disable iff (rst) wr_ack |=> !wr_ack);
    a_rd_ack_pulse: assert property (@(posedge clk) disable iff (rst) rd_ack |=> !rd_ack);

endmodule

// File: tdma_timeslot_gen.sv
// Cycle-count TDMA timeslot generator, steps the slot index every slot period while enabled
`timescale 1ns/1ps

module tdma_timeslot_gen (
    input  logic    clk,
    input  logic    rst,
    tdma_cfg_if.gen cfg,
    timeslot_if.src ts
);
    tx_sched_pkg::slot_period_t cycle_cnt;
    tx_sched_pkg::slot_idx_t    slot_q;
    tx_sched_pkg::slot_idx_t    slot_index;
    logic                       enable_d;
    logic                       running;
    logic                       slot_last;

    // Running follows the enable register directly, so it rises on the writing edge
    assign running    = cfg.tdma_enable;
    assign slot_index = running ? slot_q : '0;

    // Periods of 0 and 1 both give one-cycle slots
    assign slot_last = (cfg.slot_period == '0) || (cycle_cnt >= cfg.slot_period - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
            slot_q    <= '0;
            enable_d  <= 1'b0;
        end else begin
            enable_d <= cfg.tdma_enable;
            if (!cfg.tdma_enable) begin
                cycle_cnt <= '0;  // Next enable starts at slot 0, cycle 0
                slot_q    <= '0;
            end else if (slot_last) begin
                cycle_cnt <= '0;
                slot_q    <= slot_q + 1'b1;  // Wraps at slot count
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
        end
    end

    assign ts.slot_index     = slot_index;
    assign ts.running        = running;
    assign ts.schedule_start = running && !enable_d;
    assign ts.slot_start     = running && (cycle_cnt == '0);

    assign cfg.running  = running;
    assign cfg.cur_slot = slot_index;

    // Every slot start after the first one continues a running schedule one slot further
    a_slot_step: assert property (@(posedge clk) disable iff (rst)
        ts.slot_start && !ts.schedule_start |->
            $past(ts.running) && ts.slot_index == $past(ts.slot_index) + 1'b1);

endmodule

// File: tdma_queue_ctrl.sv
// Per-slot queue mask table, turns the current timeslot into the allowed queue mask
`timescale 1ns/1ps
`include "tx_sched_consts.svh"

module tdma_queue_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    tdma_cfg_if.ctrl                  cfg,
    timeslot_if.dst                   ts,
    output tx_sched_pkg::queue_mask_t allowed
);
    tx_sched_pkg::queue_mask_t slot_mask [`TDMA_SLOT_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `TDMA_SLOT_COUNT; i++) begin
                slot_mask[i] <= '0;
            end
        end else if (cfg.mask_wr) begin
            slot_mask[cfg.mask_wr_slot] <= cfg.mask_wr_data;
        end
    end

    assign cfg.mask_rd_data = slot_mask[cfg.mask_rd_slot];  // Register readback

    // Without a running schedule every queue may be served
    assign allowed = ts.running ? slot_mask[ts.slot_index] : '1;

    // A schedule opens with slot 0 and only out of the stopped state
    a_sched_open: assert property (@(posedge clk) disable iff (rst)
        ts.schedule_start |-> ts.slot_start && ts.slot_index == '0 && !$past(ts.running));

endmodule

// File: tx_sched_rr.sv
// Round-robin transmit scheduler, collects doorbells and issues one tagged request per pending queue
`timescale 1ns/1ps
`include "tx_sched_consts.svh"

module tx_sched_rr (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sched_enable,
    input  tx_sched_pkg::queue_mask_t allowed,
    input  tx_sched_pkg::queue_idx_t  doorbell_queue,
    input  logic                      doorbell_valid,
    output tx_sched_pkg::queue_idx_t  tx_req_queue,
    output tx_sched_pkg::tx_tag_t     tx_req_tag,
    output logic                      tx_req_valid,
    input  logic                      tx_req_ready
);
    typedef enum logic {
        RR_IDLE,
        RR_REQ
    } rr_state_t;

    rr_state_t                 state;
    tx_sched_pkg::queue_mask_t pending;
    tx_sched_pkg::queue_mask_t eligible;
    tx_sched_pkg::queue_idx_t  pick;
    logic                      pick_found;
    logic                      handshake;

    assign eligible     = pending & allowed;
    assign tx_req_valid = (state == RR_REQ);
    assign handshake    = tx_req_valid && tx_req_ready;

    // Search starts one after the last grant, held in the request register
    always_comb begin
        tx_sched_pkg::queue_idx_t idx;
        idx        = tx_req_queue;
        pick       = tx_req_queue;
        pick_found = 1'b0;
        for (int i = 0; i < `TX_QUEUE_COUNT; i++) begin
            idx = idx + 1'b1;
            if (!pick_found && eligible[idx]) begin
                pick       = idx;
                pick_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= RR_IDLE;
            pending      <= '0;
            tx_req_tag   <= '0;
            tx_req_queue <= '1;  // Last grant 7, first search from queue 0
        end else begin
            // Pending bit stays set until the request completes, so repeat doorbells merge
            if (handshake) begin
                pending[tx_req_queue] <= 1'b0;
            end
            if (doorbell_valid) begin
                pending[doorbell_queue] <= 1'b1;  // Same-edge doorbell wins over the clear
            end

            case (state)
                RR_IDLE: begin
                    if (sched_enable && pick_found) begin
                        state        <= RR_REQ;
                        tx_req_queue <= pick;
                    end
                end
                RR_REQ: begin
                    if (tx_req_ready) begin
                        state      <= RR_IDLE;
                        tx_req_tag <= tx_req_tag + 1'b1;
                    end
                end
                default: state <= RR_IDLE;
            endcase
        end
    end

    // Request is held unchanged under back-pressure
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        tx_req_valid && !tx_req_ready |=>
            tx_req_valid && $stable(tx_req_queue) && $stable(tx_req_tag));

endmodule

// File: tx_sched_block.sv
// Transmit scheduler top level for one port, register file plus TDMA gating plus round-robin scheduler
`timescale 1ns/1ps

module tx_sched_block (
    input  logic                     clk,
    input  logic                     rst,

    // Host register port
    input  tx_sched_pkg::reg_addr_t  wr_addr,
    input  tx_sched_pkg::reg_data_t  wr_data,
    input  logic                     wr_en,
    output logic                     wr_ack,
    input  tx_sched_pkg::reg_addr_t  rd_addr,
    input  logic                     rd_en,
    output tx_sched_pkg::reg_data_t  rd_data,
    output logic                     rd_ack,

    // Doorbells
    input  tx_sched_pkg::queue_idx_t doorbell_queue,
    input  logic                     doorbell_valid,

    // Transmit request
    output tx_sched_pkg::queue_idx_t tx_req_queue,
    output tx_sched_pkg::tx_tag_t    tx_req_tag,
    output logic                     tx_req_valid,
    input  logic                     tx_req_ready,

    output tx_sched_pkg::tx_dest_t   dest  // Fixed destination for every request
);
    tdma_cfg_if                cfg_if ();
    timeslot_if                ts_if ();
    tx_sched_pkg::queue_mask_t allowed;
    logic                      sched_enable;

    tx_sched_regs u_regs (
        .clk          (clk),
        .rst          (rst),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .wr_en        (wr_en),
        .wr_ack       (wr_ack),
        .rd_addr      (rd_addr),
        .rd_en        (rd_en),
        .rd_data      (rd_data),
        .rd_ack       (rd_ack),
        .cfg          (cfg_if.regs),
        .sched_enable (sched_enable),
        .dest         (dest)
    );

    tdma_timeslot_gen u_timeslot_gen (
        .clk (clk),
        .rst (rst),
        .cfg (cfg_if.gen),
        .ts  (ts_if.src)
    );

    tdma_queue_ctrl u_queue_ctrl (
        .clk     (clk),
        .rst     (rst),
        .cfg     (cfg_if.ctrl),
        .ts      (ts_if.dst),
        .allowed (allowed)
    );

    tx_sched_rr u_rr (
        .clk            (clk),
        .rst            (rst),
        .sched_enable   (sched_enable),
        .allowed        (allowed),
        .doorbell_queue (doorbell_queue),
        .doorbell_valid (doorbell_valid),
        .tx_req_queue   (tx_req_queue),
        .tx_req_tag     (tx_req_tag),
        .tx_req_valid   (tx_req_valid),
        .tx_req_ready   (tx_req_ready)
    );

endmodule

// File: tb_tx_sched_block.sv
// Directed testbench for the transmit scheduler top level, run with the modules of project.f
`timescale 1ns/1ps
`include "tx_sched_consts.svh"

module tb_tx_sched_block;
    localparam int CLK_PERIOD  = 40;
    localparam int REQ_WAIT    = 16;   // Cycles allowed for an untimed request
    localparam int SLOT_PERIOD = 200;
    // Sum of the per-test windows plus reset
    localparam int WATCHDOG_CYCLES = 8 + 100 + 150 + 80 + 80 + 2000;

    logic                     clk;
    logic                     rst;
    tx_sched_pkg::reg_addr_t  wr_addr;
    tx_sched_pkg::reg_data_t  wr_data;
    logic                     wr_en;
    logic                     wr_ack;
    tx_sched_pkg::reg_addr_t  rd_addr;
    logic                     rd_en;
    tx_sched_pkg::reg_data_t  rd_data;
    logic                     rd_ack;
    tx_sched_pkg::queue_idx_t doorbell_queue;
    logic                     doorbell_valid;
    tx_sched_pkg::queue_idx_t tx_req_queue;
    tx_sched_pkg::tx_tag_t    tx_req_tag;
    logic                     tx_req_valid;
    logic                     tx_req_ready;
    tx_sched_pkg::tx_dest_t   dest;
    tx_sched_pkg::tx_tag_t    exp_tag;  // Tag of the next expected request

    tx_sched_block dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        abort_run($sformatf("error at %0d ns: %s expected 0x%0h, got 0x%0h",
                            $time, name, expected, actual));
    endtask

    task automatic reg_write(input tx_sched_pkg::reg_addr_t addr,
                             input tx_sched_pkg::reg_data_t data);
        wr_addr = addr;
        wr_data = data;
        wr_en   = 1'b1;
        @(negedge clk);
        assert (wr_ack) else abort_run($sformatf("no write ack for address 0x%0h", addr));
        wr_en = 1'b0;
        @(negedge clk);  // Ack drops before the next access
    endtask

    task automatic reg_read(input tx_sched_pkg::reg_addr_t addr,
                            output tx_sched_pkg::reg_data_t data);
        rd_addr = addr;
        rd_en   = 1'b1;
        @(negedge clk);
        assert (rd_ack) else abort_run($sformatf("no read ack for address 0x%0h", addr));
        data  = rd_data;
        rd_en = 1'b0;
        @(negedge clk);
    endtask

    task automatic reg_read_check(input tx_sched_pkg::reg_addr_t addr,
                                  input tx_sched_pkg::reg_data_t expected);
        tx_sched_pkg::reg_data_t got;
        reg_read(addr, got);
        assert (got === expected)
            else report_mismatch($sformatf("rd_data[0x%0h]", addr), expected, got);
    endtask

    task automatic ring(input tx_sched_pkg::queue_idx_t q);
        doorbell_queue = q;
        doorbell_valid = 1'b1;
        @(negedge clk);
        doorbell_valid = 1'b0;
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!tx_req_valid) else report_mismatch("tx_req_valid", 0, tx_req_valid);
        end
    endtask

    // Waits for valid and checks queue and the running tag count
    task automatic wait_req(input tx_sched_pkg::queue_idx_t q, input int limit);
        int n;
        n = 0;
        while (!tx_req_valid && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (tx_req_valid)
            else abort_run($sformatf("no request for queue %0d within %0d cycles", q, limit));
        assert (tx_req_queue === q) else report_mismatch("tx_req_queue", q, tx_req_queue);
        assert (tx_req_tag === exp_tag) else report_mismatch("tx_req_tag", exp_tag, tx_req_tag);
    endtask

    task automatic finish_req(input tx_sched_pkg::queue_idx_t q, input int hold);
        repeat (hold) begin  // Request must hold while ready is low
            @(negedge clk);
            assert (tx_req_valid) else abort_run("tx_req_valid dropped under back-pressure");
            assert (tx_req_queue === q) else report_mismatch("tx_req_queue", q, tx_req_queue);
            assert (tx_req_tag === exp_tag)
                else report_mismatch("tx_req_tag", exp_tag, tx_req_tag);
        end
        tx_req_ready = 1'b1;
        @(negedge clk);
        tx_req_ready = 1'b0;
        assert (!tx_req_valid) else abort_run("tx_req_valid still high after the handshake");
        exp_tag = exp_tag + 1'b1;
    endtask

    task automatic expect_req(input tx_sched_pkg::queue_idx_t q, input int hold,
                              input int limit);
        wait_req(q, limit);
        finish_req(q, hold);
    endtask

    task automatic register_readback();
        tx_sched_pkg::tx_dest_t     dest_val;
        tx_sched_pkg::slot_period_t period_val;
        tx_sched_pkg::queue_mask_t  mask_val;
        assert (dest === 8'h00) else report_mismatch("dest", 0, dest);
        reg_read_check(`REG_BLOCK_TYPE, 32'h0000C004);
        reg_read_check(`REG_BLOCK_VER, 32'h00000300);
        dest_val = tx_sched_pkg::tx_dest_t'($urandom);
        reg_write(`REG_SCHED_DEST, {24'h0, dest_val});
        reg_read_check(`REG_SCHED_DEST, {24'h0, dest_val});
        assert (dest === dest_val) else report_mismatch("dest", dest_val, dest);
        period_val = tx_sched_pkg::slot_period_t'($urandom);
        reg_write(`REG_TDMA_SLOT_PERIOD, {16'h0, period_val});
        reg_read_check(`REG_TDMA_SLOT_PERIOD, {16'h0, period_val});
        for (int i = 0; i < `TDMA_SLOT_COUNT; i++) begin
            mask_val = tx_sched_pkg::queue_mask_t'($urandom);
            reg_write(`REG_TDMA_MASK_BASE + 4 * i, {24'h0, mask_val});
            reg_read_check(`REG_TDMA_MASK_BASE + 4 * i, {24'h0, mask_val});
        end
        // Nothing lives at 0x100
        rd_addr = 16'h0100;
        rd_en   = 1'b1;
        repeat (4) begin
            @(negedge clk);
            assert (!rd_ack) else report_mismatch("rd_ack", 0, rd_ack);
        end
        rd_en = 1'b0;
        @(negedge clk);
    endtask

    task automatic scheduler_gating();
        ring(1);
        ring(3);
        ring(5);
        expect_idle(50);  // Scheduler still disabled
        reg_write(`REG_SCHED_CTRL, 32'h1);
        expect_req(1, 0, REQ_WAIT);
        expect_req(3, 0, REQ_WAIT);
        expect_req(5, 0, REQ_WAIT);
        expect_idle(20);
    endtask

    task automatic doorbell_merge();
        ring(6);
        assert (!tx_req_valid) else abort_run("request came earlier than two cycles");
        ring(6);
        expect_req(6, 20, REQ_WAIT);
        expect_idle(20);  // Second doorbell merged
    endtask

    task automatic round_robin_wrap();
        ring(5);
        ring(2);  // Both land while queue 5 waits
        ring(7);
        expect_req(5, 2, REQ_WAIT);
        expect_req(7, 0, REQ_WAIT);
        expect_req(2, 0, REQ_WAIT);
        expect_idle(10);
    endtask

    task automatic tdma_gating();
        reg_write(`REG_TDMA_SLOT_PERIOD, SLOT_PERIOD);
        reg_write(`REG_TDMA_MASK_BASE + 0, 32'h0);
        reg_write(`REG_TDMA_MASK_BASE + 4, 32'h0);
        reg_write(`REG_TDMA_MASK_BASE + 8, 32'h10);  // Queue 4 only
        reg_write(`REG_TDMA_MASK_BASE + 12, 32'h0);
        reg_write(`REG_TDMA_CTRL, 32'h1);
        reg_read_check(`REG_TDMA_STATUS, 32'h0000_0001);
        ring(4);
        ring(0);
        wait_req(4, `TDMA_SLOT_COUNT * SLOT_PERIOD);
        reg_read_check(`REG_TDMA_STATUS, 32'h0000_0201);
        finish_req(4, 0);
        expect_idle(`TDMA_SLOT_COUNT * SLOT_PERIOD);  // Queue 0 blocked in every slot
        reg_write(`REG_TDMA_CTRL, 32'h0);
        expect_req(0, 0, REQ_WAIT);
        reg_read_check(`REG_TDMA_STATUS, 32'h0);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired before the tests completed");
    end

    initial begin
        void'($urandom(32'heef9_5c1f));
        clk            = 1'b0;
        rst            = 1'b1;
        wr_addr        = '0;
        wr_data        = '0;
        wr_en          = 1'b0;
        rd_addr        = '0;
        rd_en          = 1'b0;
        doorbell_queue = '0;
        doorbell_valid = 1'b0;
        tx_req_ready   = 1'b0;
        exp_tag        = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        register_readback();
        scheduler_gating();
        doorbell_merge();
        round_robin_wrap();
        tdma_gating();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: project.f
+incdir+.
tx_sched_pkg.sv
tx_sched_ifs.sv
tx_sched_regs.sv
tdma_timeslot_gen.sv
tdma_queue_ctrl.sv
tx_sched_rr.sv
tx_sched_block.sv
tb_tx_sched_block.sv
